//--- logic/dmi_pkg.sv
// DMI bridge common definitions
`default_nettype none

package dmi_pkg;

	localparam int DMI_ADDR_W = 7;
	localparam int DMI_DATA_W = 32;
	localparam int DMI_OP_W   = 2;
	localparam int DMI_REQ_W  = DMI_ADDR_W + DMI_DATA_W + DMI_OP_W;

	typedef logic [DMI_ADDR_W-1:0] dmi_addr_t;
	typedef logic [DMI_DATA_W-1:0] dmi_data_t;
	typedef logic [DMI_OP_W-1:0]   dmi_op_t;
	typedef logic [1:0]            dmi_status_t;
	typedef logic [DMI_REQ_W-1:0]  dmi_req_t;   // {addr, data, op}.
	typedef logic [31:0]           ahb_addr_t;
	typedef logic [1:0]            htrans_t;

	localparam dmi_op_t DMI_OP_NOP   = 2'd0;
	localparam dmi_op_t DMI_OP_READ  = 2'd1;
	localparam dmi_op_t DMI_OP_WRITE = 2'd2;
	localparam dmi_op_t DMI_OP_RSV   = 2'd3;

	localparam dmi_status_t DMI_ST_OK     = 2'd0;
	localparam dmi_status_t DMI_ST_FAILED = 2'd2;

	localparam htrans_t HTRANS_IDLE   = 2'd0;
	localparam htrans_t HTRANS_NONSEQ = 2'd2;

	// transfer controller states.
	typedef enum logic [2:0] {
		IDLE,
		ADDR,
		DATA,
		DRAIN,
		ACK
	} xfer_state_e;

endpackage

`default_nettype wire

//--- logic/dmi_ctrl_if.sv
// Bridge control interface
`timescale 1ns/1ps
`default_nettype none

interface dmi_ctrl_if import dmi_pkg::*; ();

	logic    load;      // capture the request word.
	logic    start;     // address phase on the bus.
	logic    in_data;   // data phase running.
	logic    finish;    // result is final.
	logic    fail;
	logic    timeout;
	dmi_op_t op;        // captured op.

	modport fsm (
		output load, start, in_data, finish, fail,
		input  op, timeout
	);

	modport timer (
		input  start, in_data,
		output timeout
	);

	modport datapath (
		input  load, finish, fail,
		output op
	);

endinterface

`default_nettype wire

//--- logic/dmi_ahb_if.sv
// Internal AHB-lite bus
`timescale 1ns/1ps
`default_nettype none

interface dmi_ahb_if import dmi_pkg::*; ();

	htrans_t   htrans;
	ahb_addr_t haddr;
	logic      hwrite;
	dmi_data_t hwdata;
	logic      hready;
	logic      hresp;
	dmi_data_t hrdata;

	// transfer sequencing side of the master.
	modport master_ctrl (
		output htrans,
		input  hready, hresp
	);

	// address and data side of the master.
	modport master_data (
		output haddr, hwrite, hwdata,
		input  hrdata
	);

	modport target (
		input  htrans, haddr, hwrite, hwdata,
		output hready, hresp, hrdata
	);

endinterface

`default_nettype wire

//--- logic/dmi_xfer_fsm.sv
// DMI transfer controller
`timescale 1ns/1ps
`default_nettype none

module dmi_xfer_fsm import dmi_pkg::*; (
	input  logic           dmi_hclk,
	input  logic           dmi_hresetn,
	input  logic           tap_dmi_req,
	output logic           dmi_tap_ack,
	dmi_ctrl_if.fsm        ctrl,
	dmi_ahb_if.master_ctrl bus
);

	xfer_state_e state;
	xfer_state_e state_nxt;
	logic        bus_op;

	assign bus_op = (ctrl.op == DMI_OP_READ) || (ctrl.op == DMI_OP_WRITE);

	assign ctrl.load    = (state == IDLE) && tap_dmi_req && !dmi_tap_ack;
	assign ctrl.start   = (state == ADDR) && bus_op;
	assign ctrl.in_data = (state == DATA);
	assign bus.htrans   = ctrl.start ? HTRANS_NONSEQ : HTRANS_IDLE;

	always_comb begin
		state_nxt   = state;
		ctrl.finish = 1'b0;
		ctrl.fail   = 1'b0;
		unique case (state)
			IDLE: begin
				if (ctrl.load)
					state_nxt = ADDR;
			end
			ADDR: begin
				if (bus_op) begin
					state_nxt = DATA;
				end else begin
					// nop and reserved op finish here, no bus transfer.
					ctrl.finish = 1'b1;
					ctrl.fail   = (ctrl.op == DMI_OP_RSV);
					state_nxt   = ACK;
				end
			end
			DATA: begin
				if (bus.hready) begin
					ctrl.finish = 1'b1;
					ctrl.fail   = bus.hresp;  // second error cycle.
					state_nxt   = ACK;
				end else if (ctrl.timeout) begin
					state_nxt = DRAIN;
				end
			end
			DRAIN: begin
				// let the target finish, result is failed anyway.
				if (bus.hready) begin
					ctrl.finish = 1'b1;
					ctrl.fail   = 1'b1;
					state_nxt   = ACK;
				end
			end
			ACK: begin
				if (!tap_dmi_req)
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge dmi_hclk or negedge dmi_hresetn) begin
		if (!dmi_hresetn) begin
			state       <= IDLE;
			dmi_tap_ack <= 1'b0;
		end else begin
			state       <= state_nxt;
			dmi_tap_ack <= (state_nxt == ACK);  // drops the cycle after req falls.
		end
	end

endmodule

`default_nettype wire

//--- logic/dmi_wait_timer.sv
// Data phase stall timer
`timescale 1ns/1ps
`default_nettype none

module dmi_wait_timer #(
	parameter int dmi_timeout = 8
) (
	input  logic     dmi_hclk,
	input  logic     dmi_hresetn,
	dmi_ctrl_if.timer ctrl,
	input  logic     hready
);

	localparam int cnt_w = (dmi_timeout > 0) ? $clog2(dmi_timeout + 1) : 1;
	localparam logic [cnt_w-1:0] cnt_max = cnt_w'(dmi_timeout);

	logic [cnt_w-1:0] stall_cnt;

	always_ff @(posedge dmi_hclk or negedge dmi_hresetn) begin
		if (!dmi_hresetn) begin
			stall_cnt <= '0;
		end else if (ctrl.start) begin
			stall_cnt <= '0;
		end else if (ctrl.in_data && !hready && (stall_cnt != cnt_max)) begin
			stall_cnt <= stall_cnt + 1'b1;  // saturates at the limit.
		end
	end

	assign ctrl.timeout = (stall_cnt == cnt_max);

endmodule

`default_nettype wire

//--- logic/dmi_req_regs.sv
// DMI request and reply registers
`timescale 1ns/1ps
`default_nettype none

module dmi_req_regs import dmi_pkg::*; (
	input  logic           dmi_hclk,
	input  logic           dmi_hresetn,
	input  dmi_req_t       tap_dmi_data,
	output dmi_data_t      dmi_tap_hrdata,
	output dmi_status_t    dmi_tap_status,
	dmi_ctrl_if.datapath   ctrl,
	dmi_ahb_if.master_data bus
);

	dmi_req_t  req_q;
	dmi_addr_t req_addr;
	dmi_data_t req_data;
	dmi_op_t   req_op;
	logic      rd_done;

	// request word stays put for the whole transfer.
	always_ff @(posedge dmi_hclk) begin
		if (ctrl.load)
			req_q <= tap_dmi_data;
	end

	assign req_addr = req_q[DMI_REQ_W-1 -: DMI_ADDR_W];
	assign req_data = req_q[DMI_OP_W +: DMI_DATA_W];
	assign req_op   = req_q[DMI_OP_W-1:0];

	assign ctrl.op    = req_op;
	assign bus.haddr  = ahb_addr_t'({req_addr, 2'b00});  // word to byte address.
	assign bus.hwrite = (req_op == DMI_OP_WRITE);
	assign bus.hwdata = req_data;

	assign rd_done = ctrl.finish && !ctrl.fail && (req_op == DMI_OP_READ);

	always_ff @(posedge dmi_hclk or negedge dmi_hresetn) begin
		if (!dmi_hresetn) begin
			dmi_tap_status <= DMI_ST_OK;
		end else if (ctrl.finish) begin
			dmi_tap_status <= ctrl.fail ? DMI_ST_FAILED : DMI_ST_OK;
		end
	end

	// failed reads keep the last good value.
	always_ff @(posedge dmi_hclk or negedge dmi_hresetn) begin
		if (!dmi_hresetn) begin
			dmi_tap_hrdata <= '0;
		end else if (rd_done) begin
			dmi_tap_hrdata <= bus.hrdata;
		end
	end

endmodule

`default_nettype wire

//--- logic/dmi_reg_target.sv
// Debug register target
`timescale 1ns/1ps
`default_nettype none

module dmi_reg_target import dmi_pkg::*; #(
	parameter int fast_wait = 1,
	parameter int slow_wait = 12
) (
	input  logic      dmi_hclk,
	input  logic      dmi_hresetn,
	dmi_ahb_if.target bus
);

	localparam int max_wait = (slow_wait > fast_wait) ? slow_wait : fast_wait;
	localparam int wait_w   = (max_wait > 1) ? $clog2(max_wait + 1) : 1;

	dmi_data_t       regs [16];
	dmi_addr_t       word_addr;
	logic            addr_ok;
	logic            busy;
	logic            err;
	logic            write_q;
	logic [3:0]      idx_q;
	logic [wait_w-1:0] wait_cnt;
	logic            done;

	assign word_addr = bus.haddr[2 +: DMI_ADDR_W];
	assign addr_ok   = bus.hready && (bus.htrans == HTRANS_NONSEQ);
	assign done      = busy && (wait_cnt == '0);

	assign bus.hready = !busy || (wait_cnt == '0);
	assign bus.hresp  = busy && err;
	assign bus.hrdata = regs[idx_q];

	always_ff @(posedge dmi_hclk or negedge dmi_hresetn) begin
		if (!dmi_hresetn) begin
			busy     <= 1'b0;
			err      <= 1'b0;
			write_q  <= 1'b0;
			idx_q    <= '0;
			wait_cnt <= '0;
		end else if (addr_ok) begin
			busy    <= 1'b1;
			write_q <= bus.hwrite;
			idx_q   <= word_addr[3:0];  // alias region folds onto the same registers.
			if (word_addr[6]) begin
				err      <= 1'b0;
				wait_cnt <= wait_w'(slow_wait);
			end else if (word_addr[5:4] != 2'b00) begin
				err      <= 1'b1;
				wait_cnt <= wait_w'(1);  // two cycle error response.
			end else begin
				err      <= 1'b0;
				wait_cnt <= wait_w'(fast_wait);
			end
		end else if (done) begin
			busy <= 1'b0;
			err  <= 1'b0;
		end else if (busy) begin
			wait_cnt <= wait_cnt - 1'b1;
		end
	end

	always_ff @(posedge dmi_hclk or negedge dmi_hresetn) begin
		if (!dmi_hresetn) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (done && write_q && !err) begin
			regs[idx_q] <= bus.hwdata;
		end
	end

endmodule

`default_nettype wire

//--- logic/dmi_subsys.sv
// DMI bridge subsystem
`timescale 1ns/1ps
`default_nettype none

module dmi_subsys import dmi_pkg::*; #(
	parameter int dmi_timeout = 8,
	parameter int fast_wait   = 1,
	parameter int slow_wait   = 12
) (
	input  logic        dmi_hclk,
	input  logic        dmi_hresetn,
	input  logic        tap_dmi_req,
	input  dmi_req_t    tap_dmi_data,
	output logic        dmi_tap_ack,
	output dmi_data_t   dmi_tap_hrdata,
	output dmi_status_t dmi_tap_status
);

	dmi_ctrl_if ctrl_if ();
	dmi_ahb_if  ahb_if ();

	dmi_xfer_fsm dmi_xfer_fsm_inst (
		.dmi_hclk    (dmi_hclk),
		.dmi_hresetn (dmi_hresetn),
		.tap_dmi_req (tap_dmi_req),
		.dmi_tap_ack (dmi_tap_ack),
		.ctrl        (ctrl_if.fsm),
		.bus         (ahb_if.master_ctrl)
	);

	dmi_wait_timer #(
		.dmi_timeout (dmi_timeout)
	) dmi_wait_timer_inst (
		.dmi_hclk    (dmi_hclk),
		.dmi_hresetn (dmi_hresetn),
		.ctrl        (ctrl_if.timer),
		.hready      (ahb_if.hready)
	);

	dmi_req_regs dmi_req_regs_inst (
		.dmi_hclk       (dmi_hclk),
		.dmi_hresetn    (dmi_hresetn),
		.tap_dmi_data   (tap_dmi_data),
		.dmi_tap_hrdata (dmi_tap_hrdata),
		.dmi_tap_status (dmi_tap_status),
		.ctrl           (ctrl_if.datapath),
		.bus            (ahb_if.master_data)
	);

	dmi_reg_target #(
		.fast_wait (fast_wait),
		.slow_wait (slow_wait)
	) dmi_reg_target_inst (
		.dmi_hclk    (dmi_hclk),
		.dmi_hresetn (dmi_hresetn),
		.bus         (ahb_if.target)
	);

endmodule

`default_nettype wire

//--- verif/dmi_subsys_checker.sv
// DMI handshake assertions
`timescale 1ns/1ps
`default_nettype none

module dmi_subsys_checker import dmi_pkg::*; (
	input logic    dmi_hclk,
	input logic    dmi_hresetn,
	input logic    tap_dmi_req,
	input logic    dmi_tap_ack,
	input htrans_t htrans
);

	int fail_count = 0;

	// ack drops in the cycle after req is seen low.
	ack_release: assert property (@(posedge dmi_hclk) disable iff (!dmi_hresetn)
		(dmi_tap_ack && !tap_dmi_req) |=> !dmi_tap_ack)
		else begin
			$error("ack still high one cycle after req fell");
			fail_count++;
		end

	single_nonseq: assert property (@(posedge dmi_hclk) disable iff (!dmi_hresetn)
		(htrans == HTRANS_NONSEQ) |=> (htrans == HTRANS_IDLE))
		else begin
			$error("address phase longer than one cycle");
			fail_count++;
		end

	no_xfer_in_ack: assert property (@(posedge dmi_hclk) disable iff (!dmi_hresetn)
		dmi_tap_ack |-> (htrans != HTRANS_NONSEQ))
		else begin
			$error("new transfer started while ack is high");
			fail_count++;
		end

	idle_in_reset: assert property (@(posedge dmi_hclk)
		!dmi_hresetn |-> (htrans == HTRANS_IDLE))
		else begin
			$error("bus not idle during reset");
			fail_count++;
		end

endmodule

bind dmi_xfer_fsm dmi_subsys_checker dmi_subsys_checker_inst (
	.dmi_hclk    (dmi_hclk),
	.dmi_hresetn (dmi_hresetn),
	.tap_dmi_req (tap_dmi_req),
	.dmi_tap_ack (dmi_tap_ack),
	.htrans      (bus.htrans)
);

`default_nettype wire

//--- verif/dmi_subsys_tb.sv
// DMI subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module dmi_subsys_tb import dmi_pkg::*; ();

	localparam int dmi_timeout = 8;
	localparam int fast_wait   = 1;
	localparam int slow_wait   = 12;
	localparam int max_rows    = 64;
	// the alias region stalls past the timer limit.
	localparam bit slow_fails  = (slow_wait > dmi_timeout);

	logic        dmi_hclk;
	logic        dmi_hresetn;
	logic        tap_dmi_req;
	dmi_req_t    tap_dmi_data;
	logic        dmi_tap_ack;
	dmi_data_t   dmi_tap_hrdata;
	dmi_status_t dmi_tap_status;

	dmi_op_t     tab_op   [max_rows];
	dmi_addr_t   tab_addr [max_rows];
	dmi_data_t   tab_data [max_rows];
	int          tab_hold [max_rows];  // cycles req stays high after ack.
	dmi_status_t tab_st   [max_rows];
	dmi_data_t   tab_rd   [max_rows];
	int          n_rows;
	dmi_data_t   model [16];
	dmi_data_t   model_rd;             // last value on dmi_tap_hrdata.
	int          errors;
	int          checks;
	int          seed;
	int          limit = 0;
	int          cycles = 0;

	dmi_subsys #(
		.dmi_timeout (dmi_timeout),
		.fast_wait   (fast_wait),
		.slow_wait   (slow_wait)
	) dmi_subsys_inst (
		.dmi_hclk       (dmi_hclk),
		.dmi_hresetn    (dmi_hresetn),
		.tap_dmi_req    (tap_dmi_req),
		.tap_dmi_data   (tap_dmi_data),
		.dmi_tap_ack    (dmi_tap_ack),
		.dmi_tap_hrdata (dmi_tap_hrdata),
		.dmi_tap_status (dmi_tap_status)
	);

	initial begin
		dmi_hclk = 1'b0;
		forever #4 dmi_hclk = ~dmi_hclk;
	end

	always @(posedge dmi_hclk) begin
		cycles <= cycles + 1;
		if ((limit > 0) && (cycles >= limit)) begin
			$display("run timed out after %0d cycles, %0d errors so far", cycles, errors);
			$display("Checks failed");
			$finish;
		end
	end

	// reference model of the register bank and the reply fields.
	task automatic add_row(input dmi_op_t op, input dmi_addr_t addr, input dmi_data_t data,
		input int hold);
		logic        bus_ok;
		logic        lands;
		dmi_status_t st;
		bus_ok = (addr < 16) || ((addr >= 64) && !slow_fails);
		lands  = (addr < 16) || (addr >= 64);  // drained writes still complete.
		if ((op == DMI_OP_WRITE) && lands)
			model[addr[3:0]] = data;
		if ((op == DMI_OP_READ) && bus_ok)
			model_rd = model[addr[3:0]];
		if (op == DMI_OP_NOP)
			st = DMI_ST_OK;
		else if (op == DMI_OP_RSV)
			st = DMI_ST_FAILED;
		else
			st = bus_ok ? DMI_ST_OK : DMI_ST_FAILED;
		tab_op[n_rows]   = op;
		tab_addr[n_rows] = addr;
		tab_data[n_rows] = data;
		tab_hold[n_rows] = hold;
		tab_st[n_rows]   = st;
		tab_rd[n_rows]   = model_rd;
		n_rows++;
	endtask

	task automatic build_table();
		add_row(DMI_OP_READ,  7'd5,  32'h0, 0);           // unwritten register.
		add_row(DMI_OP_WRITE, 7'd5,  32'hcafe_0005, 0);
		add_row(DMI_OP_READ,  7'd5,  32'h0, 0);
		add_row(DMI_OP_WRITE, 7'd71, 32'h1234_5678, 0);   // slow alias of 7.
		add_row(DMI_OP_READ,  7'd71, 32'h0, 0);
		add_row(DMI_OP_READ,  7'd7,  32'h0, 0);
		add_row(DMI_OP_WRITE, 7'd20, 32'hdead_beef, 0);   // error region.
		add_row(DMI_OP_READ,  7'd40, 32'h0, 0);
		// bus read data now differs from the last good read.
		add_row(DMI_OP_NOP,   7'd5,  32'hffff_ffff, 0);
		add_row(DMI_OP_RSV,   7'd5,  32'hffff_ffff, 0);
		add_row(DMI_OP_READ,  7'd4,  32'h0, 0);
		add_row(DMI_OP_READ,  7'd5,  32'h0, 0);
		for (int r = 0; r < 16; r++)
			add_row(DMI_OP_WRITE, dmi_addr_t'(r), dmi_data_t'($random(seed)), 0);
		for (int r = 0; r < 16; r++)
			add_row(DMI_OP_READ, dmi_addr_t'(r), 32'h0, 0);
		add_row(DMI_OP_WRITE, 7'd9, dmi_data_t'($random(seed)), 3);
		add_row(DMI_OP_READ,  7'd9, 32'h0, 0);
	endtask

	// drives one four-phase request and checks the reply.
	task automatic run_row(input int i);
		@(posedge dmi_hclk);
		tap_dmi_req  <= 1'b1;
		tap_dmi_data <= {tab_addr[i], tab_data[i], tab_op[i]};
		do @(negedge dmi_hclk); while (!dmi_tap_ack);
		checks += 2;
		assert (dmi_tap_status == tab_st[i]) else begin
			$display("MISMATCH at %0t: row %0d status %0d, expected %0d",
				$time, i, dmi_tap_status, tab_st[i]);
			errors++;
		end
		assert (dmi_tap_hrdata == tab_rd[i]) else begin
			$display("MISMATCH at %0t: row %0d read data %h, expected %h",
				$time, i, dmi_tap_hrdata, tab_rd[i]);
			errors++;
		end
		// a different write word while req stays high must be ignored.
		repeat (tab_hold[i]) begin
			@(posedge dmi_hclk);
			tap_dmi_data <= {tab_addr[i], ~tab_data[i], DMI_OP_WRITE};
		end
		@(posedge dmi_hclk);
		tap_dmi_req <= 1'b0;
		@(posedge dmi_hclk);
		@(negedge dmi_hclk);
		checks++;
		assert (!dmi_tap_ack) else begin
			$display("MISMATCH at %0t: row %0d ack still high after req fell", $time, i);
			errors++;
		end
	endtask

	initial begin
		dmi_hresetn  = 1'b1;
		tap_dmi_req  = 1'b0;
		tap_dmi_data = '0;
		errors   = 0;
		checks   = 0;
		n_rows   = 0;
		model_rd = '0;
		seed     = 19;
		for (int r = 0; r < 16; r++)
			model[r] = '0;
		build_table();
		limit = n_rows * (slow_wait + 8) + 100;
		@(posedge dmi_hclk);
		dmi_hresetn <= 1'b0;
		repeat (8) @(negedge dmi_hclk);
		checks++;
		assert ((dmi_tap_ack == 1'b0) && (dmi_tap_status == DMI_ST_OK)
			&& (dmi_tap_hrdata == '0))
		else begin
			$display("MISMATCH at %0t: outputs not cleared by reset", $time);
			errors++;
		end
		@(posedge dmi_hclk);
		dmi_hresetn <= 1'b1;
		for (int i = 0; i < n_rows; i++)
			run_row(i);
		repeat (4) @(posedge dmi_hclk);
		errors += dmi_subsys_inst.dmi_xfer_fsm_inst.dmi_subsys_checker_inst.fail_count;
		$display("%0d rows, %0d checks, %0d errors", n_rows, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
logic/dmi_pkg.sv
logic/dmi_ctrl_if.sv
logic/dmi_ahb_if.sv
logic/dmi_xfer_fsm.sv
logic/dmi_wait_timer.sv
logic/dmi_req_regs.sv
logic/dmi_reg_target.sv
logic/dmi_subsys.sv
verif/dmi_subsys_checker.sv
verif/dmi_subsys_tb.sv

//--- Bender.yml
package:
  name: dmi_subsys

sources:
  - logic/dmi_pkg.sv
  - logic/dmi_ctrl_if.sv
  - logic/dmi_ahb_if.sv
  - logic/dmi_xfer_fsm.sv
  - logic/dmi_wait_timer.sv
  - logic/dmi_req_regs.sv
  - logic/dmi_reg_target.sv
  - logic/dmi_subsys.sv
  - target: simulation
    files:
      - verif/dmi_subsys_checker.sv
      - verif/dmi_subsys_tb.sv
